// File: id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// datapath widths
`define DATA_W      32
`define REG_AW      5
`define REG_NUM     32
`define IMM_W       16
`define JIDX_W      26

// register indices
`define ZERO_REG    5'd0
`define LINK_REG    5'd31   // written by jal

`endif

// File: isa_pkg.sv
`include "id_settings.svh"

package isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,    // R-type, decoded by funct
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef struct packed {
        logic [5:0]         op;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] sa;
        logic [5:0]         funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]         op;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`IMM_W-1:0]  imm;
    } i_fields_t;

    typedef struct packed {
        logic [5:0]          op;
        logic [`JIDX_W-1:0]  index;
    } j_fields_t;

    // one fetched word, three views
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } inst_u;

endpackage

// File: pipe_pkg.sv
`include "id_settings.svh"

package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,   // also address calc and link value
        ALU_SUB  = 4'h1,
        ALU_SLT  = 4'h2,
        ALU_SLTU = 4'h3,
        ALU_AND  = 4'h4,
        ALU_OR   = 4'h5,
        ALU_XOR  = 4'h6,
        ALU_SLL  = 4'h7,
        ALU_LUI  = 4'h8
    } alu_op_e;

    // decode to execute control
    typedef struct packed {
        alu_op_e            alu_op;
        logic               src1_is_sa;
        logic               src1_is_pc;
        logic               src2_is_imm;
        logic               src2_zext;     // andi/ori zero extend
        logic               src2_is_8;     // link address pc+8
        logic               res_from_mem;
        logic               mem_we;
        logic               gr_we;
        logic [`REG_AW-1:0] dest;          // 0 when nothing is written
        logic [`IMM_W-1:0]  imm;
    } ds_ctrl_t;

    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        isa_pkg::inst_u     inst;
    } stage_t;

endpackage

// File: fwd_if.sv
`include "id_settings.svh"

interface fwd_if;

    logic [`REG_AW-1:0] es_dest;
    logic [`DATA_W-1:0] es_result;
    logic               es_is_load;   // result not ready yet
    logic [`REG_AW-1:0] ms_dest;
    logic [`DATA_W-1:0] ms_result;
    logic               ws_we;
    logic [`REG_AW-1:0] ws_dest;
    logic [`DATA_W-1:0] ws_wdata;

    modport producer (
        output es_dest, es_result, es_is_load,
        output ms_dest, ms_result,
        output ws_we, ws_dest, ws_wdata
    );

    modport consumer (
        input es_dest, es_result, es_is_load,
        input ms_dest, ms_result,
        input ws_we, ws_dest, ws_wdata
    );

endinterface

// File: stage_latch.sv
module stage_latch (
    input  logic             clk,
    input  logic             reset,
    input  logic             fs_valid,
    input  pipe_pkg::stage_t fs_stage,
    input  logic             ready_go,
    input  logic             es_allowin,
    output logic             ds_allowin,
    output logic             ds_valid,
    output logic             ds_to_es_valid,
    output pipe_pkg::stage_t ds_stage
);

    logic             valid;
    pipe_pkg::stage_t stage_r;

    assign ds_allowin     = !valid || (ready_go && es_allowin);
    assign ds_to_es_valid = valid && ready_go;
    assign ds_valid       = valid;
    assign ds_stage       = stage_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (ds_allowin) begin
            valid <= fs_valid;   // empties when fetch has nothing
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            stage_r <= fs_stage;
        end
    end

    // execute stalled on an offered instruction, so it must not move
    property hold_under_backpressure;
        @(posedge clk) disable iff (reset)
            (ds_to_es_valid && !es_allowin) |=> $stable(ds_stage);
    endproperty

    a_hold: assert property (hold_under_backpressure)
        else $error("decode stage changed under back-pressure");

endmodule

// File: inst_decoder.sv
`include "id_settings.svh"

module inst_decoder (
    input  isa_pkg::inst_u     inst,
    output pipe_pkg::ds_ctrl_t ctrl,
    output logic               rs_used,
    output logic               rt_used,
    output logic               is_beq,
    output logic               is_bne,
    output logic               is_j,
    output logic               is_jal,
    output logic               is_jr
);

    logic op_special;
    logic inst_addu;
    logic inst_subu;
    logic inst_and;
    logic inst_or;
    logic inst_xor;
    logic inst_slt;
    logic inst_sltu;
    logic inst_sll;
    logic inst_addiu;
    logic inst_andi;
    logic inst_ori;
    logic inst_lui;
    logic inst_lw;
    logic inst_sw;
    logic alu_rr;
    logic dst_is_rt;
    logic gr_we;

    assign op_special = inst.r.op == isa_pkg::OP_SPECIAL;

    assign inst_addu = op_special && inst.r.funct == isa_pkg::FN_ADDU && inst.r.sa == '0;
    assign inst_subu = op_special && inst.r.funct == isa_pkg::FN_SUBU && inst.r.sa == '0;
    assign inst_and  = op_special && inst.r.funct == isa_pkg::FN_AND  && inst.r.sa == '0;
    assign inst_or   = op_special && inst.r.funct == isa_pkg::FN_OR   && inst.r.sa == '0;
    assign inst_xor  = op_special && inst.r.funct == isa_pkg::FN_XOR  && inst.r.sa == '0;
    assign inst_slt  = op_special && inst.r.funct == isa_pkg::FN_SLT  && inst.r.sa == '0;
    assign inst_sltu = op_special && inst.r.funct == isa_pkg::FN_SLTU && inst.r.sa == '0;
    assign inst_sll  = op_special && inst.r.funct == isa_pkg::FN_SLL  && inst.r.rs == '0;
    assign is_jr     = op_special && inst.r.funct == isa_pkg::FN_JR
                       && inst.r.rt == '0 && inst.r.rd == '0 && inst.r.sa == '0;

    assign inst_addiu = inst.i.op == isa_pkg::OP_ADDIU;
    assign inst_andi  = inst.i.op == isa_pkg::OP_ANDI;
    assign inst_ori   = inst.i.op == isa_pkg::OP_ORI;
    assign inst_lui   = inst.i.op == isa_pkg::OP_LUI && inst.i.rs == '0;
    assign inst_lw    = inst.i.op == isa_pkg::OP_LW;
    assign inst_sw    = inst.i.op == isa_pkg::OP_SW;
    assign is_beq     = inst.i.op == isa_pkg::OP_BEQ;
    assign is_bne     = inst.i.op == isa_pkg::OP_BNE;
    assign is_j       = inst.j.op == isa_pkg::OP_J;
    assign is_jal     = inst.j.op == isa_pkg::OP_JAL;

    assign alu_rr    = inst_addu | inst_subu | inst_and | inst_or | inst_xor
                     | inst_slt | inst_sltu;
    assign dst_is_rt = inst_addiu | inst_andi | inst_ori | inst_lui | inst_lw;
    assign gr_we     = alu_rr | inst_sll | dst_is_rt | is_jal;   // unknown words stay quiet

    assign rs_used = alu_rr | inst_addiu | inst_andi | inst_ori | inst_lw | inst_sw
                   | is_beq | is_bne | is_jr;
    assign rt_used = alu_rr | inst_sll | inst_sw | is_beq | is_bne;

    always_comb begin
        if (inst_subu) begin
            ctrl.alu_op = pipe_pkg::ALU_SUB;
        end else if (inst_slt) begin
            ctrl.alu_op = pipe_pkg::ALU_SLT;
        end else if (inst_sltu) begin
            ctrl.alu_op = pipe_pkg::ALU_SLTU;
        end else if (inst_and || inst_andi) begin
            ctrl.alu_op = pipe_pkg::ALU_AND;
        end else if (inst_or || inst_ori) begin
            ctrl.alu_op = pipe_pkg::ALU_OR;
        end else if (inst_xor) begin
            ctrl.alu_op = pipe_pkg::ALU_XOR;
        end else if (inst_sll) begin
            ctrl.alu_op = pipe_pkg::ALU_SLL;
        end else if (inst_lui) begin
            ctrl.alu_op = pipe_pkg::ALU_LUI;
        end else begin
            ctrl.alu_op = pipe_pkg::ALU_ADD;   // addu, addiu, lw, sw, jal
        end
        ctrl.src1_is_sa   = inst_sll;
        ctrl.src1_is_pc   = is_jal;
        ctrl.src2_is_imm  = inst_addiu | inst_andi | inst_ori | inst_lui | inst_lw | inst_sw;
        ctrl.src2_zext    = inst_andi | inst_ori;
        ctrl.src2_is_8    = is_jal;
        ctrl.res_from_mem = inst_lw;
        ctrl.mem_we       = inst_sw;
        ctrl.gr_we        = gr_we;
        if (!gr_we) begin
            ctrl.dest = `ZERO_REG;
        end else if (is_jal) begin
            ctrl.dest = `LINK_REG;
        end else if (dst_is_rt) begin
            ctrl.dest = inst.i.rt;
        end else begin
            ctrl.dest = inst.r.rd;
        end
        ctrl.imm = inst.i.imm;
    end

    // branch unit picks its target assuming a single flag
    always_comb begin
        a_one_branch: assert ($onehot0({is_beq, is_bne, is_j, is_jal, is_jr}))
            else $error("more than one branch flag decoded");
    end

endmodule

// File: operand_read.sv
`include "id_settings.svh"

module operand_read (
    input  logic               clk,
    fwd_if.consumer            fwd,
    input  logic [`REG_AW-1:0] rs,
    input  logic [`REG_AW-1:0] rt,
    input  logic               rs_used,
    input  logic               rt_used,
    output logic [`DATA_W-1:0] rs_value,
    output logic [`DATA_W-1:0] rt_value,
    output logic               ready_go
);

    logic [`DATA_W-1:0] regs [`REG_NUM];
    logic               rs_load_hit;
    logic               rt_load_hit;

    always_ff @(posedge clk) begin
        if (fwd.ws_we && fwd.ws_dest != `ZERO_REG) begin
            regs[fwd.ws_dest] <= fwd.ws_wdata;
        end
    end

    // youngest producer wins
    function automatic logic [`DATA_W-1:0] pick(input logic [`REG_AW-1:0] idx);
        logic [`DATA_W-1:0] value;
        if (idx == `ZERO_REG) begin
            value = '0;
        end else if (idx == fwd.es_dest) begin
            value = fwd.es_result;
        end else if (idx == fwd.ms_dest) begin
            value = fwd.ms_result;
        end else if (fwd.ws_we && idx == fwd.ws_dest) begin
            value = fwd.ws_wdata;   // same-cycle write-back
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_comb begin
        rs_value = pick(rs);
        rt_value = pick(rt);
    end

    assign rs_load_hit = rs_used && rs != `ZERO_REG && fwd.es_is_load && rs == fwd.es_dest;
    assign rt_load_hit = rt_used && rt != `ZERO_REG && fwd.es_is_load && rt == fwd.es_dest;
    assign ready_go    = !(rs_load_hit || rt_load_hit);   // load-use stall

endmodule

// File: branch_unit.sv
`include "id_settings.svh"

module branch_unit (
    input  logic [`DATA_W-1:0] pc,
    input  isa_pkg::inst_u     inst,
    input  logic               is_beq,
    input  logic               is_bne,
    input  logic               is_j,
    input  logic               is_jal,
    input  logic               is_jr,
    input  logic [`DATA_W-1:0] rs_value,
    input  logic [`DATA_W-1:0] rt_value,
    input  logic               issue,
    output logic               br_taken,
    output logic [`DATA_W-1:0] br_target
);

    logic [`DATA_W-1:0] pc_plus4;
    logic [`DATA_W-1:0] br_offset;
    logic               rs_eq_rt;
    logic               cond_met;

    assign pc_plus4  = pc + `DATA_W'(4);
    assign br_offset = {{(`DATA_W-`IMM_W-2){inst.i.imm[`IMM_W-1]}}, inst.i.imm, 2'b00};
    assign rs_eq_rt  = rs_value == rt_value;

    assign cond_met = (is_beq && rs_eq_rt)
                   || (is_bne && !rs_eq_rt)
                   || is_j || is_jal || is_jr;
    assign br_taken = cond_met && issue;   // only once operands are final

    always_comb begin
        if (is_jr) begin
            br_target = rs_value;
        end else if (is_j || is_jal) begin
            br_target = {pc_plus4[`DATA_W-1:`DATA_W-4], inst.j.index, 2'b00};
        end else begin
            br_target = pc_plus4 + br_offset;
        end
    end

endmodule

// File: id_stage.sv
`include "id_settings.svh"

module id_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               fs_valid,
    input  logic [`DATA_W-1:0] fs_pc,
    input  logic [`DATA_W-1:0] fs_inst,
    output logic               ds_allowin,
    input  logic               es_allowin,
    output logic               ds_to_es_valid,
    output pipe_pkg::alu_op_e  alu_op,
    output logic               src1_is_sa,
    output logic               src1_is_pc,
    output logic               src2_is_imm,
    output logic               src2_zext,
    output logic               src2_is_8,
    output logic               res_from_mem,
    output logic               mem_we,
    output logic               gr_we,
    output logic [`REG_AW-1:0] dest,
    output logic [`IMM_W-1:0]  imm,
    output logic [`DATA_W-1:0] rs_value,
    output logic [`DATA_W-1:0] rt_value,
    output logic [`DATA_W-1:0] ds_pc,
    input  logic [`REG_AW-1:0] es_dest,
    input  logic [`DATA_W-1:0] es_result,
    input  logic               es_is_load,
    input  logic [`REG_AW-1:0] ms_dest,
    input  logic [`DATA_W-1:0] ms_result,
    input  logic               ws_we,
    input  logic [`REG_AW-1:0] ws_dest,
    input  logic [`DATA_W-1:0] ws_wdata,
    output logic               br_taken,
    output logic [`DATA_W-1:0] br_target
);

    pipe_pkg::stage_t   fs_stage;
    pipe_pkg::stage_t   ds_stage;
    pipe_pkg::ds_ctrl_t ctrl;
    logic               ds_valid;
    logic               ready_go;
    logic               rs_used;
    logic               rt_used;
    logic               is_beq;
    logic               is_bne;
    logic               is_j;
    logic               is_jal;
    logic               is_jr;

    fwd_if fwd ();

    assign fwd.es_dest    = es_dest;
    assign fwd.es_result  = es_result;
    assign fwd.es_is_load = es_is_load;
    assign fwd.ms_dest    = ms_dest;
    assign fwd.ms_result  = ms_result;
    assign fwd.ws_we      = ws_we;
    assign fwd.ws_dest    = ws_dest;
    assign fwd.ws_wdata   = ws_wdata;

    assign fs_stage = {fs_pc, fs_inst};

    stage_latch u_latch (
        .clk            (clk),
        .reset          (reset),
        .fs_valid       (fs_valid),
        .fs_stage       (fs_stage),
        .ready_go       (ready_go),
        .es_allowin     (es_allowin),
        .ds_allowin     (ds_allowin),
        .ds_valid       (ds_valid),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_stage       (ds_stage)
    );

    inst_decoder u_dec (
        .inst    (ds_stage.inst),
        .ctrl    (ctrl),
        .rs_used (rs_used),
        .rt_used (rt_used),
        .is_beq  (is_beq),
        .is_bne  (is_bne),
        .is_j    (is_j),
        .is_jal  (is_jal),
        .is_jr   (is_jr)
    );

    operand_read u_opr (
        .clk      (clk),
        .fwd      (fwd),
        .rs       (ds_stage.inst.r.rs),
        .rt       (ds_stage.inst.r.rt),
        .rs_used  (rs_used),
        .rt_used  (rt_used),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .ready_go (ready_go)
    );

    branch_unit u_br (
        .pc        (ds_stage.pc),
        .inst      (ds_stage.inst),
        .is_beq    (is_beq),
        .is_bne    (is_bne),
        .is_j      (is_j),
        .is_jal    (is_jal),
        .is_jr     (is_jr),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .issue     (ds_valid && ready_go),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    assign alu_op       = ctrl.alu_op;
    assign src1_is_sa   = ctrl.src1_is_sa;
    assign src1_is_pc   = ctrl.src1_is_pc;
    assign src2_is_imm  = ctrl.src2_is_imm;
    assign src2_zext    = ctrl.src2_zext;
    assign src2_is_8    = ctrl.src2_is_8;
    assign res_from_mem = ctrl.res_from_mem;
    assign mem_we       = ctrl.mem_we;
    assign gr_we        = ctrl.gr_we;
    assign dest         = ctrl.dest;
    assign imm          = ctrl.imm;
    assign ds_pc        = ds_stage.pc;

endmodule

// File: id_checker.sv
`include "id_settings.svh"

module id_checker (
    input  logic clk, reset, fs_valid, ds_allowin, es_allowin, ds_to_es_valid,
    input  logic [`DATA_W-1:0] fs_pc, fs_inst, rs_value, rt_value, ds_pc, br_target,
    input  pipe_pkg::alu_op_e alu_op,
    input  logic src1_is_sa, src1_is_pc, src2_is_imm, src2_zext, src2_is_8,
    input  logic res_from_mem, mem_we, gr_we, es_is_load, ws_we, br_taken,
    input  logic [`REG_AW-1:0] dest, es_dest, ms_dest, ws_dest,
    input  logic [`IMM_W-1:0] imm,
    input  logic [`DATA_W-1:0] es_result, ms_result, ws_wdata,
    output int errors,
    output int checks
);

    logic               held;
    logic [`DATA_W-1:0] held_pc;
    logic [`DATA_W-1:0] held_inst;
    logic [`DATA_W-1:0] shadow [`REG_NUM];

    initial begin
        errors = 0;
        checks = 0;
        held = 1'b0;
        for (int k = 0; k < `REG_NUM; k++) shadow[k] = '0;
    end

    // expected control bundle, straight from the opcode/funct table
    function automatic pipe_pkg::ds_ctrl_t expect_ctrl(input logic [31:0] w);
        pipe_pkg::ds_ctrl_t c;
        logic we_rd;
        logic we_rt;
        c = '0;
        c.alu_op = pipe_pkg::ALU_ADD;
        c.imm = w[15:0];
        we_rd = 1'b0;
        we_rt = 1'b0;
        case (w[31:26])
            6'h00: begin
                if (w[10:6] == 0 && w[5:0] inside {6'h21, 6'h23, 6'h24, 6'h25, 6'h26,
                                                   6'h2a, 6'h2b}) begin
                    we_rd = 1'b1;
                    case (w[5:0])
                        6'h23: c.alu_op = pipe_pkg::ALU_SUB;
                        6'h24: c.alu_op = pipe_pkg::ALU_AND;
                        6'h25: c.alu_op = pipe_pkg::ALU_OR;
                        6'h26: c.alu_op = pipe_pkg::ALU_XOR;
                        6'h2a: c.alu_op = pipe_pkg::ALU_SLT;
                        6'h2b: c.alu_op = pipe_pkg::ALU_SLTU;
                        default: c.alu_op = pipe_pkg::ALU_ADD;
                    endcase
                end else if (w[5:0] == 6'h00 && w[25:21] == 0) begin
                    we_rd = 1'b1;   // sll
                    c.alu_op = pipe_pkg::ALU_SLL;
                    c.src1_is_sa = 1'b1;
                end
            end
            6'h09: begin we_rt = 1'b1; c.src2_is_imm = 1'b1; end
            6'h0c: begin we_rt = 1'b1; c.src2_is_imm = 1'b1; c.src2_zext = 1'b1;
                         c.alu_op = pipe_pkg::ALU_AND; end
            6'h0d: begin we_rt = 1'b1; c.src2_is_imm = 1'b1; c.src2_zext = 1'b1;
                         c.alu_op = pipe_pkg::ALU_OR; end
            6'h0f: if (w[25:21] == 0) begin
                       we_rt = 1'b1;
                       c.src2_is_imm = 1'b1;
                       c.alu_op = pipe_pkg::ALU_LUI;
                   end
            6'h23: begin we_rt = 1'b1; c.src2_is_imm = 1'b1; c.res_from_mem = 1'b1; end
            6'h2b: begin c.src2_is_imm = 1'b1; c.mem_we = 1'b1; end
            6'h03: begin c.src1_is_pc = 1'b1; c.src2_is_8 = 1'b1; end
            default: ;
        endcase
        c.gr_we = we_rd | we_rt | (w[31:26] == 6'h03);
        if (w[31:26] == 6'h03) c.dest = 5'd31;
        else if (we_rt) c.dest = w[20:16];
        else if (we_rd) c.dest = w[15:11];
        return c;
    endfunction

    // {rs read, rt read}
    function automatic logic [1:0] expect_uses(input logic [31:0] w);
        logic [5:0] op;
        logic       rr;
        logic       sll;
        logic       jr;
        op = w[31:26];
        rr = op == 6'h00 && w[10:6] == 0
             && w[5:0] inside {6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h2b};
        sll = op == 6'h00 && w[5:0] == 6'h00 && w[25:21] == 0;
        jr = op == 6'h00 && w[5:0] == 6'h08 && w[20:6] == 0;
        return {rr | jr | op inside {6'h09, 6'h0c, 6'h0d, 6'h23, 6'h2b, 6'h04, 6'h05},
                rr | sll | op inside {6'h2b, 6'h04, 6'h05}};
    endfunction

    function automatic logic [31:0] expect_operand(input logic [4:0] idx);
        if (idx == 0) return '0;
        if (idx == es_dest) return es_result;
        if (idx == ms_dest) return ms_result;
        if (ws_we && idx == ws_dest) return ws_wdata;
        return shadow[idx];
    endfunction

    function automatic logic expect_ready(input logic [31:0] w);
        logic [1:0] u;
        u = expect_uses(w);
        return !(es_is_load && es_dest != 0
                 && ((u[1] && w[25:21] == es_dest) || (u[0] && w[20:16] == es_dest)));
    endfunction

    // branch outcome if issued; returns whether the word is a branch or jump
    function automatic logic expect_branch(input logic [31:0] w, input logic [31:0] pc,
                                           output logic cond, output logic [31:0] target);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc4;
        a = expect_operand(w[25:21]);
        b = expect_operand(w[20:16]);
        pc4 = pc + 32'd4;
        cond = 1'b0;
        target = pc4 + {{14{w[15]}}, w[15:0], 2'b00};
        case (w[31:26])
            6'h04: begin cond = a == b; return 1'b1; end
            6'h05: begin cond = a != b; return 1'b1; end
            6'h02, 6'h03: begin
                cond = 1'b1;
                target = {pc4[31:28], w[25:0], 2'b00};
                return 1'b1;
            end
            6'h00: if (w[5:0] == 6'h08 && w[20:6] == 0) begin
                cond = 1'b1;
                target = a;
                return 1'b1;
            end
            default: ;
        endcase
        return 1'b0;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at time %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            held <= 1'b0;
        end else if (!held || (expect_ready(held_inst) && es_allowin)) begin
            held <= fs_valid;
            if (fs_valid) begin
                held_pc <= fs_pc;
                held_inst <= fs_inst;
            end
        end
        if (ws_we && ws_dest != 0) shadow[ws_dest] <= ws_wdata;
    end

    always @(negedge clk) begin
        pipe_pkg::ds_ctrl_t c;
        logic ready;
        logic is_br;
        logic cond;
        logic [31:0] tgt;
        if (!reset) begin
            ready = expect_ready(held_inst);
            check("ds_to_es_valid", 32'(ds_to_es_valid), 32'(held && ready));
            check("ds_allowin", 32'(ds_allowin), 32'(!held || (ready && es_allowin)));
            if (held && ready) begin
                c = expect_ctrl(held_inst);
                check("alu_op", 32'(alu_op), 32'(c.alu_op));
                check("src1_is_sa", 32'(src1_is_sa), 32'(c.src1_is_sa));
                check("src1_is_pc", 32'(src1_is_pc), 32'(c.src1_is_pc));
                check("src2_is_imm", 32'(src2_is_imm), 32'(c.src2_is_imm));
                check("src2_zext", 32'(src2_zext), 32'(c.src2_zext));
                check("src2_is_8", 32'(src2_is_8), 32'(c.src2_is_8));
                check("res_from_mem", 32'(res_from_mem), 32'(c.res_from_mem));
                check("mem_we", 32'(mem_we), 32'(c.mem_we));
                check("gr_we", 32'(gr_we), 32'(c.gr_we));
                check("dest", 32'(dest), 32'(c.dest));
                check("imm", 32'(imm), 32'(c.imm));
                check("ds_pc", ds_pc, held_pc);
                check("rs_value", rs_value, expect_operand(held_inst[25:21]));
                check("rt_value", rt_value, expect_operand(held_inst[20:16]));
            end
            is_br = expect_branch(held_inst, held_pc, cond, tgt);
            check("br_taken", 32'(br_taken), 32'(held && ready && is_br && cond));
            if (held && is_br) check("br_target", br_target, tgt);
        end
    end

endmodule

// File: tb_id_stage.sv
`include "id_settings.svh"

module tb_id_stage;

    localparam int N_PLANNED = 85;   // instructions sent over all tests
    localparam int TIMEOUT = N_PLANNED * 20 * 4;

    logic clk = 1'b0;
    logic reset, fs_valid, ds_allowin, es_allowin, ds_to_es_valid;
    logic [`DATA_W-1:0] fs_pc, fs_inst, rs_value, rt_value, ds_pc, br_target;
    pipe_pkg::alu_op_e alu_op;
    logic src1_is_sa, src1_is_pc, src2_is_imm, src2_zext, src2_is_8;
    logic res_from_mem, mem_we, gr_we, es_is_load, ws_we, br_taken;
    logic [`REG_AW-1:0] dest, es_dest, ms_dest, ws_dest;
    logic [`IMM_W-1:0] imm;
    logic [`DATA_W-1:0] es_result, ms_result, ws_wdata;
    int errors, checks;
    int tb_errors = 0;
    logic [31:0] lfsr = 32'h901c_09bc;
    logic [31:0] pc = 32'hbfc0_0000;

    id_stage DUT (.*);
    id_checker u_checker (.*);

    always #2 clk = ~clk;

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_word(input logic [4:0] rs, rt, rd, sa,
                                           input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs, rt,
                                           input logic [15:0] k);
        return {op, rs, rt, k};
    endfunction

    function automatic logic [31:0] rand_inst();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] k;
        logic [5:0]  fn [7];
        logic [5:0]  op [8];
        int          kind;
        fn = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h2b};
        op = '{6'h09, 6'h0c, 6'h0d, 6'h23, 6'h2b, 6'h04, 6'h05, 6'h02};
        kind = int'(take_bits(5)) % 20;
        rs = 5'(take_bits(5));
        rt = 5'(take_bits(5));
        rd = 5'(take_bits(5));
        k = 16'(take_bits(16));
        if (kind < 7) return r_word(rs, rt, rd, 5'd0, fn[kind]);
        if (kind == 7) return r_word(5'd0, rt, rd, 5'(take_bits(5)), 6'h00);   // sll
        if (kind < 16) return i_word(op[kind-8], rs, rt, k);
        if (kind == 16) return i_word(6'h0f, 5'd0, rt, k);                     // lui
        if (kind == 17) return {6'h03, 26'(take_bits(26))};                    // jal
        if (kind == 18) return r_word(rs, 5'd0, 5'd0, 5'd0, 6'h08);            // jr
        return take_bits(32);   // mostly unknown words
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_bypass();
        es_dest = '0;
        ms_dest = '0;
        es_is_load = 1'b0;
        ws_we = 1'b0;
    endtask

    task automatic send(input logic [31:0] w);
        fs_pc = pc;
        fs_inst = w;
        fs_valid = 1'b1;
        pc = pc + 32'd4;
        @(negedge clk);
        while (!ds_allowin) @(negedge clk);
        step();
        fs_valid = 1'b0;
    endtask

    task automatic wait_issue();
        int n;
        n = 0;
        @(negedge clk);
        while (!ds_to_es_valid && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (n >= 50) begin
            tb_errors++;
            $display("instruction never issued at time %0t", $time);
        end
        step();
    endtask

    initial begin
        reset = 1'b1;
        fs_valid = 1'b0;
        fs_pc = '0;
        fs_inst = '0;
        es_allowin = 1'b1;
        es_result = '0;
        ms_result = '0;
        ws_dest = '0;
        ws_wdata = '0;
        clear_bypass();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // register file, including a write to register 0
        for (int r = 0; r < `REG_NUM; r++) begin
            ws_we = 1'b1;
            ws_dest = 5'(r);
            ws_wdata = take_bits(32);
            step();
        end
        ws_we = 1'b0;
        send(r_word(5'd0, 5'd0, 5'd1, 5'd0, 6'h21));
        wait_issue();
        repeat (8) begin
            send(r_word(5'(take_bits(5)), 5'(take_bits(5)), 5'd2, 5'd0, 6'h21));
            wait_issue();
        end

        // bypass priority, held in place by es_allowin
        es_allowin = 1'b0;
        send(r_word(5'd9, 5'd9, 5'd3, 5'd0, 6'h25));
        es_dest = 5'd9;
        es_result = take_bits(32);
        ms_dest = 5'd9;
        ms_result = take_bits(32);
        ws_we = 1'b1;
        ws_dest = 5'd9;
        ws_wdata = take_bits(32);
        step();
        es_dest = '0;
        step();
        ms_dest = '0;
        step();
        ws_we = 1'b0;
        step();
        es_allowin = 1'b1;
        wait_issue();

        // load-use on rs, on rt, and a load to register 0
        es_dest = 5'd12;
        es_is_load = 1'b1;
        send(r_word(5'd12, 5'd4, 5'd5, 5'd0, 6'h23));
        repeat (3) step();
        es_is_load = 1'b0;
        wait_issue();
        es_is_load = 1'b1;
        send(i_word(6'h2b, 5'd6, 5'd12, 16'h0010));
        repeat (2) step();
        clear_bypass();
        wait_issue();
        es_is_load = 1'b1;
        send(r_word(5'd0, 5'd0, 5'd7, 5'd0, 6'h21));
        wait_issue();
        clear_bypass();

        // random decode with live execute and memory results
        repeat (60) begin
            es_dest = 5'(take_bits(5));
            es_result = take_bits(32);
            ms_dest = 5'(take_bits(5));
            ms_result = take_bits(32);
            send(rand_inst());
            wait_issue();
        end
        clear_bypass();

        // words outside the kept set
        send(32'hffff_ffff);
        wait_issue();
        send(r_word(5'd1, 5'd2, 5'd3, 5'd4, 6'h21));   // addu with nonzero sa
        wait_issue();
        send(i_word(6'h0f, 5'd1, 5'd6, 16'h8000));     // lui with rs set
        wait_issue();

        // branch and jump forms
        send(i_word(6'h04, 5'd3, 5'd3, 16'hfff0));
        wait_issue();
        send(i_word(6'h04, 5'd3, 5'd4, 16'h0008));     // not taken
        wait_issue();
        send(i_word(6'h05, 5'd3, 5'd4, 16'h0020));
        wait_issue();
        send(i_word(6'h05, 5'd4, 5'd4, 16'h0040));     // not taken
        wait_issue();
        send({6'h02, 26'h2a_5a5a});
        wait_issue();
        send({6'h03, 26'h01_2345});
        wait_issue();
        send(r_word(5'd5, 5'd0, 5'd0, 5'd0, 6'h08));
        wait_issue();

        // back-pressure, a second word waits at the input
        es_allowin = 1'b0;
        send(i_word(6'h09, 5'd8, 5'd9, 16'h1234));
        fs_inst = i_word(6'h0d, 5'd10, 5'd11, 16'h00ff);
        fs_pc = pc;
        fs_valid = 1'b1;
        repeat (4) step();
        es_allowin = 1'b1;
        @(negedge clk);
        while (!ds_allowin) @(negedge clk);
        step();
        fs_valid = 1'b0;
        wait_issue();

        repeat (3) step();
        $display("checks: %0d  errors: %0d  testbench errors: %0d", checks, errors, tb_errors);
        if (errors == 0 && tb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
fwd_if.sv
stage_latch.sv
inst_decoder.sv
operand_read.sv
branch_unit.sv
id_stage.sv
id_checker.sv
tb_id_stage.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert --top-module tb_id_stage -f compile.f -o sim_id
./obj_dir/sim_id > sim.log 2>&1
cat sim.log
if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0
